/* src/pu_pkg.sv */
`default_nettype none

package pu_pkg;

    // PE count and its log, fixed for one PU
    localparam int LOG_NUM_PE = 3;
    localparam int NUM_PE = 1 << LOG_NUM_PE;

    localparam int DATA_LEN = 16;

    // defaults for the top-level parameters
    localparam int BUS_STAGES_DEF = 2;
    localparam int NEIGH_STAGES_DEF = 1;
    localparam int WR_DEPTH_DEF = 4;

    // the read buffer depth also sets how many credits each destination starts with
    localparam int RD_DEPTH_DEF = 4;

    typedef logic [DATA_LEN-1:0] pe_data_t;
    typedef logic [LOG_NUM_PE-1:0] pe_addr_t;
    typedef logic [NUM_PE-1:0] pe_mask_t;

endpackage

`default_nettype wire

/* src/shift_pipe.sv */
`timescale 1ns/1ps
`default_nettype none

module shift_pipe #(
    parameter int WIDTH = 8,
    parameter int STAGES = 1
) (
    input  wire logic             clk,
    input  wire logic             rstn,
    input  wire logic [WIDTH-1:0] din,
    output logic      [WIDTH-1:0] dout
);

    generate
        if (STAGES == 0) begin : gen_bypass
            assign dout = din;
        end else begin : gen_stages
            logic [WIDTH-1:0] stage_q [STAGES];

            // every stage shifts each cycle so several items can be in flight
            always_ff @(posedge clk or negedge rstn) begin
                if (!rstn) begin
                    for (int s = 0; s < STAGES; s++) begin
                        stage_q[s] <= '0;
                    end
                end else begin
                    stage_q[0] <= din;
                    for (int s = 1; s < STAGES; s++) begin
                        stage_q[s] <= stage_q[s-1];
                    end
                end
            end

            assign dout = stage_q[STAGES-1];
        end
    endgenerate

endmodule

`default_nettype wire

/* src/bus_slave.sv */
`timescale 1ns/1ps
`default_nettype none

module bus_slave #(
    parameter int PE_ID = 0,
    parameter int WR_DEPTH = 4,
    parameter int RD_DEPTH = 4
) (
    input  wire logic             clk,
    input  wire logic             rstn,
    input  wire logic             dest_valid,
    input  wire pu_pkg::pe_addr_t dest_addr,
    input  wire pu_pkg::pe_data_t dest_data,
    output logic                  fifo_full,
    output logic                  head_valid,
    output pu_pkg::pe_addr_t      head_addr,
    output pu_pkg::pe_data_t      head_data,
    input  wire logic             grant,
    input  wire logic             deliver,
    input  wire pu_pkg::pe_data_t bus_data,
    input  wire logic             src_rq,
    output logic                  src_valid,
    output pu_pkg::pe_data_t      src_data,
    output logic                  credit_ret
);

    localparam int WR_AW = (WR_DEPTH > 1) ? $clog2(WR_DEPTH) : 1;
    localparam int WR_CW = $clog2(WR_DEPTH + 1);
    localparam int RD_AW = (RD_DEPTH > 1) ? $clog2(RD_DEPTH) : 1;
    localparam int RD_CW = $clog2(RD_DEPTH + 1);

    generate
        if (WR_DEPTH < 1 || RD_DEPTH < 1) begin : gen_bad_depth
            $error("bus_slave %0d: FIFO depths must be at least one", PE_ID);
        end
    endgenerate

    pu_pkg::pe_addr_t wr_addr_mem [WR_DEPTH];
    pu_pkg::pe_data_t wr_data_mem [WR_DEPTH];
    logic [WR_AW-1:0] wr_wptr;
    logic [WR_AW-1:0] wr_rptr;
    logic [WR_CW-1:0] wr_count;
    logic             wr_push;
    logic             wr_pop;

    pu_pkg::pe_data_t rd_mem [RD_DEPTH];
    logic [RD_AW-1:0] rd_wptr;
    logic [RD_AW-1:0] rd_rptr;
    logic [RD_CW-1:0] rd_count;
    logic             rd_pop;

    // a rejected word is simply not written, the PE keeps retrying it
    assign fifo_full = (wr_count == WR_CW'(WR_DEPTH));
    assign wr_push = dest_valid && !fifo_full;

    // the grant pops the head on the same edge the arbiter registers it
    assign wr_pop = grant && head_valid;

    assign head_valid = (wr_count != '0);
    assign head_addr = wr_addr_mem[wr_rptr];
    assign head_data = wr_data_mem[wr_rptr];

    always_ff @(posedge clk) begin
        if (wr_push) begin
            wr_addr_mem[wr_wptr] <= dest_addr;
            wr_data_mem[wr_wptr] <= dest_data;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wr_wptr <= '0;
            wr_rptr <= '0;
            wr_count <= '0;
        end else begin
            if (wr_push) begin
                wr_wptr <= (wr_wptr == WR_AW'(WR_DEPTH - 1)) ? '0 : wr_wptr + 1'b1;
            end
            if (wr_pop) begin
                wr_rptr <= (wr_rptr == WR_AW'(WR_DEPTH - 1)) ? '0 : wr_rptr + 1'b1;
            end
            wr_count <= wr_count + WR_CW'(wr_push) - WR_CW'(wr_pop);
        end
    end

    // the arbiter never sends more words than this buffer holds, so deliver always fits
    assign src_valid = (rd_count != '0);
    assign src_data = rd_mem[rd_rptr];
    assign rd_pop = src_rq && src_valid;
    assign credit_ret = rd_pop;

    always_ff @(posedge clk) begin
        if (deliver) begin
            rd_mem[rd_wptr] <= bus_data;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            rd_wptr <= '0;
            rd_rptr <= '0;
            rd_count <= '0;
        end else begin
            if (deliver) begin
                rd_wptr <= (rd_wptr == RD_AW'(RD_DEPTH - 1)) ? '0 : rd_wptr + 1'b1;
            end
            if (rd_pop) begin
                rd_rptr <= (rd_rptr == RD_AW'(RD_DEPTH - 1)) ? '0 : rd_rptr + 1'b1;
            end
            rd_count <= rd_count + RD_CW'(deliver) - RD_CW'(rd_pop);
        end
    end

endmodule

`default_nettype wire

/* src/bus_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module bus_arbiter #(
    parameter int RD_DEPTH = 4
) (
    input  wire logic             clk,
    input  wire logic             rstn,
    input  wire pu_pkg::pe_mask_t head_valid,
    input  wire pu_pkg::pe_addr_t head_addr [pu_pkg::NUM_PE],
    input  wire pu_pkg::pe_data_t head_data [pu_pkg::NUM_PE],
    input  wire pu_pkg::pe_mask_t credit_ret,
    output pu_pkg::pe_mask_t      grant,
    output pu_pkg::pe_mask_t      deliver,
    output pu_pkg::pe_data_t      bus_data
);

    localparam int CW = $clog2(RD_DEPTH + 1);

    // free read-buffer slots left at each destination
    logic [CW-1:0] credit [pu_pkg::NUM_PE];

    pu_pkg::pe_addr_t last_ptr;
    pu_pkg::pe_addr_t scan_idx;
    pu_pkg::pe_addr_t win_idx;
    logic             win_found;
    pu_pkg::pe_mask_t cand;
    pu_pkg::pe_mask_t dest_mask;

    // a slave competes only if its head has somewhere to go
    generate
        for (genvar i = 0; i < pu_pkg::NUM_PE; i++) begin : gen_cand
            assign cand[i] = head_valid[i] && (credit[head_addr[i]] != '0);
        end
    endgenerate

    // scan starts one past the last winner and wraps around to it
    always_comb begin
        win_found = 1'b0;
        win_idx = last_ptr;
        scan_idx = last_ptr;
        for (int k = 1; k <= pu_pkg::NUM_PE; k++) begin
            scan_idx = last_ptr + pu_pkg::pe_addr_t'(k);
            if (!win_found && cand[scan_idx]) begin
                win_found = 1'b1;
                win_idx = scan_idx;
            end
        end
    end

    always_comb begin
        grant = '0;
        if (win_found) begin
            grant[win_idx] = 1'b1;
        end
    end

    assign dest_mask = win_found ? (pu_pkg::pe_mask_t'(1) << head_addr[win_idx]) : '0;

    // grant takes a credit and a pop at the destination gives one back, both may coincide
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int d = 0; d < pu_pkg::NUM_PE; d++) begin
                credit[d] <= CW'(RD_DEPTH);
            end
            last_ptr <= pu_pkg::pe_addr_t'(pu_pkg::NUM_PE - 1);
            deliver <= '0;
        end else begin
            for (int d = 0; d < pu_pkg::NUM_PE; d++) begin
                credit[d] <= credit[d] - CW'(dest_mask[d]) + CW'(credit_ret[d]);
            end
            if (win_found) begin
                last_ptr <= win_idx;
            end
            deliver <= dest_mask;
        end
    end

    always_ff @(posedge clk) begin
        bus_data <= head_data[win_idx];
    end

endmodule

`default_nettype wire

/* src/neigh_ring.sv */
`timescale 1ns/1ps
`default_nettype none

module neigh_ring #(
    parameter int STAGES = 1
) (
    input  wire logic             clk,
    input  wire logic             rstn,
    input  wire pu_pkg::pe_data_t neigh_in [pu_pkg::NUM_PE],
    input  wire pu_pkg::pe_mask_t neigh_in_v,
    output pu_pkg::pe_data_t      neigh_out [pu_pkg::NUM_PE],
    output pu_pkg::pe_mask_t      neigh_out_v
);

    localparam int DL = pu_pkg::DATA_LEN;
    localparam int WIDTH = pu_pkg::NUM_PE * (DL + 1);

    logic [WIDTH-1:0] ring_in;
    logic [WIDTH-1:0] ring_out;

    // data of PE i sits in slice i, all valid bits ride in the low byte
    generate
        for (genvar i = 0; i < pu_pkg::NUM_PE; i++) begin : gen_ring
            assign ring_in[pu_pkg::NUM_PE + i*DL +: DL] = neigh_in[i];
            assign ring_in[i] = neigh_in_v[i];
            assign neigh_out[(i+1) % pu_pkg::NUM_PE] = ring_out[pu_pkg::NUM_PE + i*DL +: DL];
            assign neigh_out_v[(i+1) % pu_pkg::NUM_PE] = ring_out[i];
        end
    endgenerate

    shift_pipe #(
        .WIDTH  (WIDTH),
        .STAGES (STAGES)
    ) ring_pipe (
        .clk  (clk),
        .rstn (rstn),
        .din  (ring_in),
        .dout (ring_out)
    );

endmodule

`default_nettype wire

/* src/done_tracker.sv */
`timescale 1ns/1ps
`default_nettype none

module done_tracker (
    input  wire logic             clk,
    input  wire logic             rstn,
    input  wire logic             start,
    input  wire logic             eoc,
    input  wire pu_pkg::pe_mask_t pe_eol,
    input  wire pu_pkg::pe_mask_t pe_eoi,
    output logic                  inst_eol,
    output logic                  eoi_pu
);

    // one sticky flag per PE, set by its end-of-loop pulse
    pu_pkg::pe_mask_t eol_flags;

    assign inst_eol = &eol_flags;

    // flags drop the edge after inst_eol is seen, or when a new loop starts
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            eol_flags <= '0;
        end else if (start || eoc || inst_eol) begin
            eol_flags <= '0;
        end else begin
            eol_flags <= eol_flags | pe_eol;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            eoi_pu <= 1'b0;
        end else begin
            eoi_pu <= &pe_eoi;
        end
    end

endmodule

`default_nettype wire

/* src/pu_fabric.sv */
`timescale 1ns/1ps
`default_nettype none

module pu_fabric #(
    parameter int BUS_STAGES = pu_pkg::BUS_STAGES_DEF,
    parameter int NEIGH_STAGES = pu_pkg::NEIGH_STAGES_DEF,
    parameter int WR_DEPTH = pu_pkg::WR_DEPTH_DEF,
    parameter int RD_DEPTH = pu_pkg::RD_DEPTH_DEF
) (
    input  wire logic             clk,
    input  wire logic             rstn,
    input  wire pu_pkg::pe_mask_t dest_valid,
    input  wire pu_pkg::pe_addr_t dest_addr [pu_pkg::NUM_PE],
    input  wire pu_pkg::pe_data_t dest_data [pu_pkg::NUM_PE],
    output pu_pkg::pe_mask_t      fifo_full,
    output pu_pkg::pe_mask_t      src_valid,
    output pu_pkg::pe_data_t      src_data [pu_pkg::NUM_PE],
    input  wire pu_pkg::pe_mask_t src_rq,
    input  wire pu_pkg::pe_data_t neigh_in [pu_pkg::NUM_PE],
    input  wire pu_pkg::pe_mask_t neigh_in_v,
    output pu_pkg::pe_data_t      neigh_out [pu_pkg::NUM_PE],
    output pu_pkg::pe_mask_t      neigh_out_v,
    input  wire logic             start,
    input  wire logic             eoc,
    input  wire pu_pkg::pe_mask_t pe_eol,
    input  wire pu_pkg::pe_mask_t pe_eoi,
    output logic                  inst_eol,
    output logic                  eoi_pu
);

    // slave heads toward the arbiter
    pu_pkg::pe_mask_t head_valid;
    pu_pkg::pe_addr_t head_addr [pu_pkg::NUM_PE];
    pu_pkg::pe_data_t head_data [pu_pkg::NUM_PE];
    pu_pkg::pe_mask_t grant;
    pu_pkg::pe_mask_t credit_ret;

    // arbiter output before and after the return pipeline
    pu_pkg::pe_mask_t arb_deliver;
    pu_pkg::pe_data_t arb_bus_data;
    pu_pkg::pe_mask_t pipe_deliver;
    pu_pkg::pe_data_t pipe_bus_data;

    generate
        for (genvar i = 0; i < pu_pkg::NUM_PE; i++) begin : bus_slave_gen
            bus_slave #(
                .PE_ID    (i),
                .WR_DEPTH (WR_DEPTH),
                .RD_DEPTH (RD_DEPTH)
            ) bus_slave_inst (
                .clk        (clk),
                .rstn       (rstn),
                .dest_valid (dest_valid[i]),
                .dest_addr  (dest_addr[i]),
                .dest_data  (dest_data[i]),
                .fifo_full  (fifo_full[i]),
                .head_valid (head_valid[i]),
                .head_addr  (head_addr[i]),
                .head_data  (head_data[i]),
                .grant      (grant[i]),
                .deliver    (pipe_deliver[i]),
                .bus_data   (pipe_bus_data),
                .src_rq     (src_rq[i]),
                .src_valid  (src_valid[i]),
                .src_data   (src_data[i]),
                .credit_ret (credit_ret[i])
            );
        end
    endgenerate

    bus_arbiter #(
        .RD_DEPTH (RD_DEPTH)
    ) bus_arbiter_inst (
        .clk        (clk),
        .rstn       (rstn),
        .head_valid (head_valid),
        .head_addr  (head_addr),
        .head_data  (head_data),
        .credit_ret (credit_ret),
        .grant      (grant),
        .deliver    (arb_deliver),
        .bus_data   (arb_bus_data)
    );

    shift_pipe #(
        .WIDTH  (pu_pkg::NUM_PE + pu_pkg::DATA_LEN),
        .STAGES (BUS_STAGES)
    ) bus_pipeline (
        .clk  (clk),
        .rstn (rstn),
        .din  ({arb_deliver, arb_bus_data}),
        .dout ({pipe_deliver, pipe_bus_data})
    );

    neigh_ring #(
        .STAGES (NEIGH_STAGES)
    ) neigh_ring_inst (
        .clk         (clk),
        .rstn        (rstn),
        .neigh_in    (neigh_in),
        .neigh_in_v  (neigh_in_v),
        .neigh_out   (neigh_out),
        .neigh_out_v (neigh_out_v)
    );

    done_tracker done_tracker_inst (
        .clk      (clk),
        .rstn     (rstn),
        .start    (start),
        .eoc      (eoc),
        .pe_eol   (pe_eol),
        .pe_eoi   (pe_eoi),
        .inst_eol (inst_eol),
        .eoi_pu   (eoi_pu)
    );

endmodule

`default_nettype wire

/* verif/tb_clock.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter int PERIOD_NS = 8
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    always #(PERIOD_NS / 2) clk = ~clk;

endmodule

`default_nettype wire

/* verif/pu_fabric_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

module pu_fabric_asserts #(
    parameter int RD_DEPTH = 4,
    parameter int CW = $clog2(RD_DEPTH + 1)
) (
    input wire logic             clk,
    input wire logic             rstn,
    input wire pu_pkg::pe_mask_t grant,
    input wire pu_pkg::pe_mask_t head_valid,
    input wire pu_pkg::pe_addr_t head_addr [pu_pkg::NUM_PE],
    input wire pu_pkg::pe_data_t head_data [pu_pkg::NUM_PE],
    input wire logic [CW-1:0]    credit [pu_pkg::NUM_PE]
);

    // a slave pops its write FIFO only on a grant, so a waiting head stays put
    generate
        for (genvar i = 0; i < pu_pkg::NUM_PE; i++) begin : gen_head
            head_hold: assert property (@(posedge clk) disable iff (!rstn)
                (head_valid[i] && !grant[i]) |=>
                    (head_valid[i] && $stable(head_addr[i]) && $stable(head_data[i])))
                else $error("slave %0d changed its head without a grant", i);
        end
    endgenerate

    generate
        for (genvar d = 0; d < pu_pkg::NUM_PE; d++) begin : gen_credit
            credit_bound: assert property (@(posedge clk) disable iff (!rstn)
                credit[d] <= CW'(RD_DEPTH))
                else $error("credit of PE %0d is above the read FIFO depth", d);
        end
    endgenerate

endmodule

bind bus_arbiter pu_fabric_asserts #(
    .RD_DEPTH (RD_DEPTH)
) pu_fabric_asserts_inst (
    .clk        (clk),
    .rstn       (rstn),
    .grant      (grant),
    .head_valid (head_valid),
    .head_addr  (head_addr),
    .head_data  (head_data),
    .credit     (credit)
);

`default_nettype wire

/* verif/pu_fabric_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module pu_fabric_tb;

    localparam int BUS_STAGES = pu_pkg::BUS_STAGES_DEF;
    localparam int NEIGH_STAGES = pu_pkg::NEIGH_STAGES_DEF;
    localparam int WR_DEPTH = pu_pkg::WR_DEPTH_DEF;
    localparam int RD_DEPTH = pu_pkg::RD_DEPTH_DEF;
    localparam int NP = pu_pkg::NUM_PE;
    localparam int SEQ_W = pu_pkg::DATA_LEN - pu_pkg::LOG_NUM_PE;
    localparam int RAND_WORDS = 12;
    localparam int BP_WORDS = 8;
    localparam int BP_HOLD = 40;
    localparam int RING_LEN = 12;
    localparam int TOTAL_WORDS = 1 + NP * RAND_WORDS + (NP - 1) * BP_WORDS;
    localparam int WATCHDOG_CYCLES = TOTAL_WORDS * 40 + 500;

    logic             clk;
    logic             rstn;
    pu_pkg::pe_mask_t dest_valid;
    pu_pkg::pe_addr_t dest_addr [NP];
    pu_pkg::pe_data_t dest_data [NP];
    pu_pkg::pe_mask_t fifo_full;
    pu_pkg::pe_mask_t src_valid;
    pu_pkg::pe_data_t src_data [NP];
    pu_pkg::pe_mask_t src_rq;
    pu_pkg::pe_data_t neigh_in [NP];
    pu_pkg::pe_mask_t neigh_in_v;
    pu_pkg::pe_data_t neigh_out [NP];
    pu_pkg::pe_mask_t neigh_out_v;
    logic             start;
    logic             eoc;
    pu_pkg::pe_mask_t pe_eol;
    pu_pkg::pe_mask_t pe_eoi;
    logic             inst_eol;
    logic             eoi_pu;

    // one queue per (source, destination) pair, indexed source * NP + destination
    pu_pkg::pe_data_t sb_q [NP*NP][$];
    int               seq_no [NP*NP];
    int               words_left [NP];
    pu_pkg::pe_mask_t pend_v;
    pu_pkg::pe_addr_t pend_dst [NP];
    pu_pkg::pe_data_t pend_data [NP];
    int               outstanding;
    int               gen_mode;
    logic             full_seen;
    logic [15:0]      lfsr_state;
    string            cur_test;
    int               err_base;
    int               n_tests;
    int               n_checks;
    int               n_errors;

    tb_clock #(.PERIOD_NS(8)) tb_clock_inst (.clk(clk));

    pu_fabric #(
        .BUS_STAGES   (BUS_STAGES),
        .NEIGH_STAGES (NEIGH_STAGES),
        .WR_DEPTH     (WR_DEPTH),
        .RD_DEPTH     (RD_DEPTH)
    ) pu_fabric_inst (
        .clk (clk), .rstn (rstn),
        .dest_valid (dest_valid), .dest_addr (dest_addr), .dest_data (dest_data),
        .fifo_full (fifo_full), .src_valid (src_valid), .src_data (src_data),
        .src_rq (src_rq), .neigh_in (neigh_in), .neigh_in_v (neigh_in_v),
        .neigh_out (neigh_out), .neigh_out_v (neigh_out_v),
        .start (start), .eoc (eoc), .pe_eol (pe_eol), .pe_eoi (pe_eoi),
        .inst_eol (inst_eol), .eoi_pu (eoi_pu)
    );

    // galois LFSR, each bit taken is one shift
    function automatic int take_bits(input int n);
        int v;
        v = 0;
        for (int k = 0; k < n; k++) begin
            v = (v << 1) | int'(lfsr_state[0]);
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 16'hb400) : (lfsr_state >> 1);
        end
        return v;
    endfunction

    task automatic check_data(input pu_pkg::pe_data_t exp, input pu_pkg::pe_data_t act);
        n_checks++;
        if (act !== exp) begin
            n_errors++;
            $display("ERR %s: expected %h actual %h", cur_test, exp, act);
        end
    endtask

    task automatic check_mask(input pu_pkg::pe_mask_t exp, input pu_pkg::pe_mask_t act);
        n_checks++;
        if (act !== exp) begin
            n_errors++;
            $display("ERR %s: expected %b actual %b", cur_test, exp, act);
        end
    endtask

    task automatic check_bit(input logic exp, input logic act);
        n_checks++;
        if (act !== exp) begin
            n_errors++;
            $display("ERR %s: expected %b actual %b", cur_test, exp, act);
        end
    endtask

    task automatic report_problem(input string what);
        n_errors++;
        $display("%s: %s", cur_test, what);
    endtask

    task automatic begin_test(input string name);
        cur_test = name;
        err_base = n_errors;
    endtask

    task automatic end_test();
        n_tests++;
        $display("test %s done with %0d errors", cur_test, n_errors - err_base);
    endtask

    // outputs are sampled here, before the inputs of the new cycle are driven
    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    // every word popped this cycle must be the oldest one of its pair
    task automatic collect_arrivals();
        int s;
        for (int d = 0; d < NP; d++) begin
            if (src_rq[d] && src_valid[d]) begin
                s = int'(src_data[d][pu_pkg::DATA_LEN-1 -: pu_pkg::LOG_NUM_PE]);
                if (sb_q[s*NP+d].size() == 0) begin
                    report_problem($sformatf("PE %0d got a word %h that was never sent",
                        d, src_data[d]));
                end else begin
                    check_data(sb_q[s*NP+d].pop_front(), src_data[d]);
                    outstanding--;
                end
            end
        end
    endtask

    task automatic make_words();
        int dst;
        int idx;
        for (int s = 0; s < NP; s++) begin
            if (!pend_v[s] && words_left[s] > 0) begin
                dst = -1;
                if (gen_mode != 0) begin
                    dst = 0;
                end else if (take_bits(1) != 0) begin
                    dst = take_bits(3);
                end
                if (dst >= 0) begin
                    idx = s * NP + dst;
                    pend_dst[s] = pu_pkg::pe_addr_t'(dst);
                    pend_data[s] = {pu_pkg::pe_addr_t'(s), SEQ_W'(seq_no[idx])};
                    seq_no[idx]++;
                    pend_v[s] = 1'b1;
                    words_left[s]--;
                end
            end
        end
    endtask

    // fifo_full follows the registered count, so its value now decides the write at the next edge
    task automatic drive_words();
        for (int s = 0; s < NP; s++) begin
            dest_valid[s] = pend_v[s];
            if (pend_v[s]) begin
                dest_addr[s] = pend_dst[s];
                dest_data[s] = pend_data[s];
                if (!fifo_full[s]) begin
                    sb_q[s*NP+int'(pend_dst[s])].push_back(pend_data[s]);
                    outstanding++;
                    pend_v[s] = 1'b0;
                end
            end
        end
    endtask

    function automatic bit traffic_idle();
        int left;
        left = 0;
        for (int s = 0; s < NP; s++) begin
            left += words_left[s];
        end
        return left == 0 && pend_v == '0 && outstanding == 0;
    endfunction

    task automatic run_traffic(input pu_pkg::pe_mask_t rq, input int max_cycles,
                               output bit done);
        done = 1'b0;
        for (int c = 0; c < max_cycles && !done; c++) begin
            tick();
            src_rq = rq;
            collect_arrivals();
            if (fifo_full != '0) begin
                full_seen = 1'b1;
            end
            make_words();
            drive_words();
            done = traffic_idle();
        end
    endtask

    task automatic test_reset();
        begin_test("reset");
        tick();
        check_bit(1'b0, inst_eol);
        check_bit(1'b0, eoi_pu);
        check_mask('0, src_valid);
        check_mask('0, neigh_out_v);
        check_mask('0, fifo_full);
        end_test();
    endtask

    task automatic test_single();
        pu_pkg::pe_data_t word;
        int lat;
        begin_test("single");
        word = {pu_pkg::pe_addr_t'(2), SEQ_W'(13'h0abc)};
        src_rq = '1;
        check_bit(1'b0, fifo_full[2]);
        dest_valid[2] = 1'b1;
        dest_addr[2] = pu_pkg::pe_addr_t'(5);
        dest_data[2] = word;
        tick();
        dest_valid[2] = 1'b0;
        lat = 1;
        while (src_valid == '0 && lat < 50) begin
            tick();
            lat++;
        end
        if (src_valid == '0) begin
            report_problem("no word reached PE 5");
        end else begin
            if (lat < 3 + BUS_STAGES) begin
                report_problem($sformatf("word arrived after only %0d cycles", lat));
            end
            check_mask(pu_pkg::pe_mask_t'(1) << 5, src_valid);
            check_data(word, src_data[5]);
            tick();
            check_mask('0, src_valid);
        end
        end_test();
    endtask

    task automatic test_random();
        bit done;
        begin_test("random");
        gen_mode = 0;
        for (int s = 0; s < NP; s++) begin
            words_left[s] = RAND_WORDS;
        end
        run_traffic('1, NP * RAND_WORDS * 20, done);
        if (!done) begin
            report_problem($sformatf("%0d accepted words never arrived", outstanding));
        end
        end_test();
    endtask

    task automatic test_backpressure();
        bit done;
        begin_test("backpressure");
        gen_mode = 1;
        full_seen = 1'b0;
        for (int s = 1; s < NP; s++) begin
            words_left[s] = BP_WORDS;
        end
        // PE 0 stops popping, so its credits run out and the senders back up
        run_traffic(~pu_pkg::pe_mask_t'(1), BP_HOLD, done);
        check_bit(1'b1, full_seen);
        run_traffic('1, (NP - 1) * BP_WORDS * 20, done);
        if (!done) begin
            report_problem($sformatf("%0d accepted words never arrived", outstanding));
        end
        end_test();
    endtask

    task automatic test_ring();
        pu_pkg::pe_data_t ring_d [RING_LEN][NP];
        pu_pkg::pe_mask_t ring_v [RING_LEN];
        begin_test("ring");
        for (int c = 0; c < RING_LEN + NEIGH_STAGES; c++) begin
            tick();
            if (c >= NEIGH_STAGES) begin
                for (int i = 0; i < NP; i++) begin
                    check_data(ring_d[c-NEIGH_STAGES][i], neigh_out[(i+1)%NP]);
                    check_bit(ring_v[c-NEIGH_STAGES][i], neigh_out_v[(i+1)%NP]);
                end
            end
            if (c < RING_LEN) begin
                ring_v[c] = pu_pkg::pe_mask_t'(take_bits(NP));
                neigh_in_v = ring_v[c];
                for (int i = 0; i < NP; i++) begin
                    ring_d[c][i] = pu_pkg::pe_data_t'(take_bits(pu_pkg::DATA_LEN));
                    neigh_in[i] = ring_d[c][i];
                end
            end else begin
                neigh_in_v = '0;
            end
        end
        end_test();
    endtask

    task automatic test_done();
        pu_pkg::pe_mask_t eoi_pat [8];
        begin_test("done");
        eoi_pat = '{8'hff, 8'h0f, 8'hff, 8'hff, 8'h00, 8'hfe, 8'hff, 8'h00};
        // PE i pulses end of loop at cycle 2i, so the last flag lands after cycle 14
        for (int c = 0; c < 20; c++) begin
            tick();
            check_bit(c == 15, inst_eol);
            pe_eol = (c % 2 == 0 && c < 16) ? pu_pkg::pe_mask_t'(1) << (c / 2) : '0;
        end
        // a start halfway through drops the flags that were already set
        for (int c = 0; c < 20; c++) begin
            tick();
            check_bit(1'b0, inst_eol);
            pe_eol = (c % 2 == 0 && c < 16) ? pu_pkg::pe_mask_t'(1) << (c / 2) : '0;
            start = (c == 7);
        end
        tick();
        eoc = 1'b1;
        tick();
        eoc = 1'b0;
        // eoc drops the upper flags left from the start test so the lower half alone cannot end the loop
        pe_eol = 8'h0f;
        tick();
        pe_eol = '0;
        check_bit(1'b0, inst_eol);
        for (int c = 0; c <= 8; c++) begin
            tick();
            if (c > 0) begin
                check_bit(eoi_pat[c-1] == 8'hff, eoi_pu);
            end
            pe_eoi = (c < 8) ? eoi_pat[c] : '0;
        end
        end_test();
    endtask

    task automatic init_inputs();
        rstn = 1'b0;
        dest_valid = '0;
        src_rq = '0;
        neigh_in_v = '0;
        start = 1'b0;
        eoc = 1'b0;
        pe_eol = '0;
        pe_eoi = '0;
        pend_v = '0;
        for (int i = 0; i < NP; i++) begin
            dest_addr[i] = '0;
            dest_data[i] = '0;
            neigh_in[i] = '0;
            words_left[i] = 0;
        end
        for (int i = 0; i < NP * NP; i++) begin
            seq_no[i] = 0;
        end
        outstanding = 0;
        gen_mode = 0;
        full_seen = 1'b0;
        lfsr_state = 16'd3034;
        n_tests = 0;
        n_checks = 0;
        n_errors = 0;
    endtask

    initial begin
        init_inputs();
        repeat (8) @(posedge clk);
        #1;
        rstn = 1'b1;
        test_reset();
        test_single();
        test_random();
        test_backpressure();
        test_ring();
        test_done();
        $display("tests %0d, checks %0d, errors %0d", n_tests, n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles, a test hung", WATCHDOG_CYCLES);
        $display("Verification failed");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
src/pu_pkg.sv
src/shift_pipe.sv
src/bus_slave.sv
src/bus_arbiter.sv
src/neigh_ring.sv
src/done_tracker.sv
src/pu_fabric.sv
verif/tb_clock.sv
verif/pu_fabric_asserts.sv
verif/pu_fabric_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= pu_fabric_tb
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "Verification passed"

clean:
	rm -rf $(OBJ_DIR)
